/* hdl/romsys_pkg.sv */
/*
 * ROM system package
 * Shared widths, loader memory map and the request structs that
 * travel between the client slots, the loader and the SDRAM controller.
 */
`default_nettype none

package romsys_pkg;

    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] sdram_data_t;
    typedef logic [1:0]  bank_t;
    typedef logic [25:0] loader_addr_t;

    // Client address widths, bytes for the CPUs and words for graphics
    localparam int MAIN_AW = 16;
    localparam int SND_AW  = 15;
    localparam int CHAR_AW = 13;
    localparam int SCR_AW  = 14;
    localparam int OBJ_AW  = 14;

    // Loader byte address where each bank begins, bank 0 at zero
    localparam loader_addr_t BA1_START = 26'h001_0000;
    localparam loader_addr_t BA2_START = 26'h001_8000;
    localparam loader_addr_t BA3_START = 26'h002_4000;
    localparam loader_addr_t LOAD_END  = 26'h002_C000;

    // Scroll tiles sit above the characters in bank 2
    localparam sdram_addr_t SCR_OFFSET = 22'h00_2000;

    // Read request from a slot to one bank
    typedef struct packed {
        logic        rd;
        sdram_addr_t addr;
    } bank_req_t;

    // Programming write from the loader
    typedef struct packed {
        logic        we;
        bank_t       ba;
        sdram_addr_t addr;
        sdram_data_t data;
        logic [1:0]  mask;      // active low
    } prog_req_t;

endpackage

`default_nettype wire

/* hdl/rom_download.sv */
/*
 * ROM download
 * Packs loader bytes into 16-bit words, picks the bank by address region
 * and issues one programming write per word, held until acknowledged.
 * Object tiles are stored with their low address bits reordered.
 */
`timescale 1ns/1ps
`default_nettype none

module rom_download import romsys_pkg::*; (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic         ioctl_rom,
    input  wire logic         ioctl_wr,
    input  wire loader_addr_t ioctl_addr,
    input  wire logic [7:0]   ioctl_dout,
    output prog_req_t         prog,
    input  wire logic         prog_ack
);

    bank_t        region;
    loader_addr_t start;
    loader_addr_t offset;
    sdram_addr_t  word_off;
    sdram_addr_t  store_addr;
    logic         byte_wr;

    logic [7:0]   even_byte;
    logic         wr_we;
    bank_t        wr_ba;
    sdram_addr_t  wr_addr;
    sdram_data_t  wr_data;

    assign byte_wr = ioctl_rom && ioctl_wr && (ioctl_addr < LOAD_END);

    // Region decode, highest bank first
    always_comb begin
        if (ioctl_addr >= BA3_START) begin
            region = 2'd3;
            start  = BA3_START;
        end else if (ioctl_addr >= BA2_START) begin
            region = 2'd2;
            start  = BA2_START;
        end else if (ioctl_addr >= BA1_START) begin
            region = 2'd1;
            start  = BA1_START;
        end else begin
            region = 2'd0;
            start  = '0;
        end
    end

    assign offset   = ioctl_addr - start;
    assign word_off = sdram_addr_t'(offset >> 1);

    // Objects interleave: bit 5 moves down next to bit 0
    always_comb begin
        store_addr = word_off;
        if (region == 2'd3) begin
            store_addr[5:0] = {word_off[4:1], word_off[5], word_off[0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_we <= 1'b0;
        end else if (byte_wr && ioctl_addr[0]) begin
            wr_we <= 1'b1;
        end else if (prog_ack) begin
            wr_we <= 1'b0;
        end
    end

    // Even byte waits for its partner, odd byte ends up in the low half
    always_ff @(posedge clk) begin
        if (byte_wr) begin
            if (!ioctl_addr[0]) begin
                even_byte <= ioctl_dout;
            end else begin
                wr_data <= {even_byte, ioctl_dout};
                wr_ba   <= region;
                wr_addr <= store_addr;
            end
        end
    end

    assign prog = '{we: wr_we, ba: wr_ba, addr: wr_addr, data: wr_data, mask: 2'b00};

endmodule

`default_nettype wire

/* hdl/rom_slot.sv */
/*
 * ROM client slot
 * Caches the last word read from its bank and serves the client from it.
 * A miss issues one bank read and waits for ack, then rdy. 8-bit clients
 * get the byte picked by the lowest address bit.
 */
`timescale 1ns/1ps
`default_nettype none

module rom_slot import romsys_pkg::*; #(
    parameter int          DW     = 16,
    parameter int          AW     = 14,
    parameter sdram_addr_t OFFSET = '0
) (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          cs,
    input  wire logic [AW-1:0] addr,
    output logic      [DW-1:0] data,
    output logic               ok,
    output bank_req_t          req,
    input  wire logic          ack,
    input  wire logic          rdy,
    input  wire sdram_data_t   data_read
);

    localparam int WW = (DW == 8) ? AW - 1 : AW;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t        state;
    logic [WW-1:0] word_addr;
    logic [WW-1:0] cached_addr;
    sdram_data_t   cached_data;
    sdram_addr_t   req_addr;
    logic          req_rd;
    logic          valid;
    logic          ok_r;
    logic          match;
    logic          hit;
    logic          fill;
    logic          miss_start;

    // Byte clients drop the lowest bit to get the word address
    assign word_addr  = addr[AW-1:AW-WW];
    assign match      = cached_addr == word_addr;
    assign hit        = valid && match;
    assign fill       = (state == ST_WAIT) && rdy;
    assign miss_start = (state == ST_IDLE) && cs && !hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            req_rd <= 1'b0;
            valid  <= 1'b0;
            ok_r   <= 1'b0;
        end else begin
            ok_r <= cs && match && (valid || fill);
            case (state)
                ST_IDLE: if (miss_start) begin
                    state  <= ST_REQ;
                    req_rd <= 1'b1;
                    valid  <= 1'b0;
                end
                ST_REQ: if (ack) begin
                    state  <= ST_WAIT;
                    req_rd <= 1'b0;
                end
                ST_WAIT: if (rdy) begin
                    state <= ST_IDLE;
                    valid <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            cached_addr <= word_addr;
            req_addr    <= OFFSET + sdram_addr_t'(word_addr);
        end
        if (fill) begin
            cached_data <= data_read;
        end
    end

    // Drops at once if the client moves away from the cached word
    assign ok  = ok_r && cs && hit;
    assign req = '{rd: req_rd, addr: req_addr};

    generate
        if (DW == 8) begin : g_byte
            assign data = addr[0] ? cached_data[7:0] : cached_data[15:8];
        end else begin : g_word
            assign data = cached_data;
        end
    endgenerate

endmodule

`default_nettype wire

/* hdl/rom_slot_pair.sv */
/*
 * Two ROM slots on one bank
 * Character and scroll slots share bank 2. One pending request is granted
 * at a time, alternating when both wait, and the grant holds until rdy.
 */
`timescale 1ns/1ps
`default_nettype none

module rom_slot_pair import romsys_pkg::*; #(
    parameter int AW0 = CHAR_AW,
    parameter int AW1 = SCR_AW
) (
    input  wire logic           clk,
    input  wire logic           reset,

    input  wire logic           cs0,
    input  wire logic [AW0-1:0] addr0,
    output sdram_data_t         data0,
    output logic                ok0,

    input  wire logic           cs1,
    input  wire logic [AW1-1:0] addr1,
    output sdram_data_t         data1,
    output logic                ok1,

    output bank_req_t           req,
    input  wire logic           ack,
    input  wire logic           rdy,
    input  wire sdram_data_t    data_read
);

    bank_req_t req0;
    bank_req_t req1;
    logic      ack0;
    logic      ack1;
    logic      rdy0;
    logic      rdy1;
    logic      locked;
    logic      owner;
    logic      sel;

    // owner also remembers who was served last
    assign sel  = locked ? owner : ((req0.rd && req1.rd) ? !owner : req1.rd);
    assign req  = sel ? req1 : req0;
    assign ack0 = ack && !sel;
    assign ack1 = ack && sel;
    assign rdy0 = rdy && !sel;
    assign rdy1 = rdy && sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked <= 1'b0;
            owner  <= 1'b0;
        end else if (locked) begin
            if (rdy) begin
                locked <= 1'b0;
            end
        end else if (req0.rd || req1.rd) begin
            locked <= 1'b1;
            owner  <= sel;
        end
    end

    rom_slot #(
        .DW     ( 16   ),
        .AW     ( AW0  ),
        .OFFSET ( '0   )
    ) u_slot0 (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cs        ( cs0       ),
        .addr      ( addr0     ),
        .data      ( data0     ),
        .ok        ( ok0       ),
        .req       ( req0      ),
        .ack       ( ack0      ),
        .rdy       ( rdy0      ),
        .data_read ( data_read )
    );

    rom_slot #(
        .DW     ( 16         ),
        .AW     ( AW1        ),
        .OFFSET ( SCR_OFFSET )
    ) u_slot1 (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cs        ( cs1       ),
        .addr      ( addr1     ),
        .data      ( data1     ),
        .ok        ( ok1       ),
        .req       ( req1      ),
        .ack       ( ack1      ),
        .rdy       ( rdy1      ),
        .data_read ( data_read )
    );

endmodule

`default_nettype wire

/* hdl/game_sdram.sv */
/*
 * Game SDRAM client side
 * Loads the ROM image through the programming port, then serves the
 * main CPU, sound CPU, characters, scroll and objects from four banks.
 */
`timescale 1ns/1ps
`default_nettype none

module game_sdram import romsys_pkg::*; (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               lvbl,

    // Main CPU, bank 0
    input  wire logic               main_cs,
    input  wire logic [MAIN_AW-1:0] main_addr,
    output logic      [7:0]         main_data,
    output logic                    main_ok,

    // Sound CPU, bank 1
    input  wire logic               snd_cs,
    input  wire logic [SND_AW-1:0]  snd_addr,
    output logic      [7:0]         snd_data,
    output logic                    snd_ok,

    // Characters and scroll, bank 2
    input  wire logic [CHAR_AW-1:0] char_addr,
    output sdram_data_t             char_data,
    output logic                    char_ok,
    input  wire logic [SCR_AW-1:0]  scr_addr,
    output sdram_data_t             scr_data,
    output logic                    scr_ok,

    // Objects, bank 3
    input  wire logic               obj_cs,
    input  wire logic [OBJ_AW-1:0]  obj_addr,
    output sdram_data_t             obj_data,
    output logic                    obj_ok,

    // SDRAM controller read side
    output bank_req_t               bank_req [4],
    input  wire logic [3:0]         bank_ack,
    input  wire logic [3:0]         bank_rdy,
    input  wire sdram_data_t        data_read,

    // Loader
    input  wire logic               ioctl_rom,
    input  wire logic               ioctl_wr,
    input  wire loader_addr_t       ioctl_addr,
    input  wire logic [7:0]         ioctl_dout,
    output prog_req_t               prog,
    input  wire logic               prog_ack,
    output logic                    dwnld_busy
);

    logic rom_last;

    // Busy covers the loader window plus any write still in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            rom_last   <= 1'b0;
            dwnld_busy <= 1'b0;
        end else begin
            rom_last   <= ioctl_rom;
            dwnld_busy <= ioctl_rom || rom_last || (prog.we && !prog_ack);
        end
    end

    rom_download u_download (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .ioctl_rom  ( ioctl_rom  ),
        .ioctl_wr   ( ioctl_wr   ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .prog       ( prog       ),
        .prog_ack   ( prog_ack   )
    );

    rom_slot #(.DW(8), .AW(MAIN_AW)) u_main (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .cs        ( main_cs     ),
        .addr      ( main_addr   ),
        .data      ( main_data   ),
        .ok        ( main_ok     ),
        .req       ( bank_req[0] ),
        .ack       ( bank_ack[0] ),
        .rdy       ( bank_rdy[0] ),
        .data_read ( data_read   )
    );

    rom_slot #(.DW(8), .AW(SND_AW)) u_snd (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .cs        ( snd_cs      ),
        .addr      ( snd_addr    ),
        .data      ( snd_data    ),
        .ok        ( snd_ok      ),
        .req       ( bank_req[1] ),
        .ack       ( bank_ack[1] ),
        .rdy       ( bank_rdy[1] ),
        .data_read ( data_read   )
    );

    // Graphics fetch only while the blanking signal allows it
    rom_slot_pair #(.AW0(CHAR_AW), .AW1(SCR_AW)) u_gfx (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .cs0       ( lvbl        ),
        .addr0     ( char_addr   ),
        .data0     ( char_data   ),
        .ok0       ( char_ok     ),
        .cs1       ( lvbl        ),
        .addr1     ( scr_addr    ),
        .data1     ( scr_data    ),
        .ok1       ( scr_ok      ),
        .req       ( bank_req[2] ),
        .ack       ( bank_ack[2] ),
        .rdy       ( bank_rdy[2] ),
        .data_read ( data_read   )
    );

    // Object data stays in the interleaved order the loader wrote
    rom_slot #(.DW(16), .AW(OBJ_AW)) u_obj (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .cs        ( obj_cs      ),
        .addr      ( obj_addr    ),
        .data      ( obj_data    ),
        .ok        ( obj_ok      ),
        .req       ( bank_req[3] ),
        .ack       ( bank_ack[3] ),
        .rdy       ( bank_rdy[3] ),
        .data_read ( data_read   )
    );

endmodule

`default_nettype wire

/* dv/sdram_model.sv */
/*
 * SDRAM model
 * Four banks behind a programming port and a read port. One read is
 * served at a time, with a latency of 1 to 6 cycles from an LCG.
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_model import romsys_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire bank_req_t   bank_req [4],
    output logic [3:0]       bank_ack,
    output logic [3:0]       bank_rdy,
    output sdram_data_t      data_read,
    input  wire prog_req_t   prog,
    output logic             prog_ack
);

    // Flat storage indexed by {bank, word}
    sdram_data_t mem [0:131071];

    logic [31:0] lat_state = 32'h3165;
    logic        busy;
    logic [1:0]  cur_bank;
    logic [14:0] cur_addr;
    logic [2:0]  wait_cnt;

    function automatic logic [31:0] next_latency_rand();
        lat_state = lat_state * 32'd1103515245 + 32'd12345;
        return lat_state;
    endfunction

    // Programming writes, acknowledged for one cycle
    always @(negedge clk) begin
        if (reset) begin
            prog_ack <= 1'b0;
        end else if (prog_ack) begin
            prog_ack <= 1'b0;
        end else if (prog.we) begin
            prog_ack <= 1'b1;
            // Mask bits are active low, bit 1 guards the high byte
            if (!prog.mask[1]) begin
                mem[{prog.ba, prog.addr[14:0]}][15:8] <= prog.data[15:8];
            end
            if (!prog.mask[0]) begin
                mem[{prog.ba, prog.addr[14:0]}][7:0] <= prog.data[7:0];
            end
        end
    end

    // Read server, lowest bank first
    always @(negedge clk) begin
        logic found;
        found = 1'b0;
        bank_ack <= 4'b0000;
        bank_rdy <= 4'b0000;
        if (reset) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 3'd0) begin
                bank_rdy[cur_bank] <= 1'b1;
                data_read          <= mem[{cur_bank, cur_addr}];
                busy               <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 3'd1;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (!found && bank_req[b].rd) begin
                    found       = 1'b1;
                    cur_bank    <= 2'(b);
                    cur_addr    <= bank_req[b].addr[14:0];
                    bank_ack[b] <= 1'b1;
                    wait_cnt    <= 3'(next_latency_rand() % 32'd6);
                    busy        <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_game_sdram.sv */
/*
 * Testbench for game_sdram
 * Loads a random ROM image, checks the bank contents against the memory
 * map, then reads through every client slot.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_game_sdram import romsys_pkg::*; ();

    localparam int N_CPU   = 200;
    localparam int N_GFX   = 100;
    localparam int N_OBJ   = 100;
    localparam int N_READS = 2 * N_CPU + N_GFX + N_OBJ + 1;

    logic clk = 1'b0;
    logic reset, lvbl;
    logic main_cs, snd_cs, obj_cs;
    logic [MAIN_AW-1:0] main_addr;
    logic [SND_AW-1:0]  snd_addr;
    logic [CHAR_AW-1:0] char_addr;
    logic [SCR_AW-1:0]  scr_addr;
    logic [OBJ_AW-1:0]  obj_addr;
    logic [7:0]         main_data, snd_data;
    sdram_data_t        char_data, scr_data, obj_data, data_read;
    logic               main_ok, snd_ok, char_ok, scr_ok, obj_ok;
    bank_req_t          bank_req [4];
    logic [3:0]         bank_ack, bank_rdy;
    logic               ioctl_rom, ioctl_wr, prog_ack, dwnld_busy;
    loader_addr_t       ioctl_addr;
    logic [7:0]         ioctl_dout;
    prog_req_t          prog;

    logic [31:0] rng_state = 32'h3165;
    logic [7:0]  image [0:int'(LOAD_END)-1];
    sdram_data_t ref_mem [0:131071];
    bit          ref_written [0:131071];
    logic [MAIN_AW-1:0] main_list [N_CPU];
    logic [SND_AW-1:0]  snd_list [N_CPU];

    always #2 clk = ~clk;

    game_sdram dut0 (.*);

    sdram_model model0 (
        .clk(clk), .reset(reset), .bank_req(bank_req), .bank_ack(bank_ack),
        .bank_rdy(bank_rdy), .data_read(data_read), .prog(prog), .prog_ack(prog_ack)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task automatic expect_equal(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic expect_true(string what, logic cond);
        assert (cond === 1'b1) else begin
            $display("%s did not hold", what);
            $display("ERRORS FOUND");
            $fatal(1, "condition failed");
        end
    endtask

    // Reference bank contents from the memory map rules
    task automatic build_reference();
        logic [1:0]  ba;
        logic [14:0] w;
        int          off;
        for (int i = 0; i < int'(LOAD_END); i += 2) begin
            if (i >= int'(BA3_START)) begin
                ba  = 2'd3;
                off = i - int'(BA3_START);
            end else if (i >= int'(BA2_START)) begin
                ba  = 2'd2;
                off = i - int'(BA2_START);
            end else if (i >= int'(BA1_START)) begin
                ba  = 2'd1;
                off = i - int'(BA1_START);
            end else begin
                ba  = 2'd0;
                off = i;
            end
            w = 15'(off / 2);
            if (ba == 2'd3) begin
                w = {w[14:6], w[4:1], w[5], w[0]};
            end
            ref_mem[{ba, w}]     = {image[i], image[i + 1]};
            ref_written[{ba, w}] = 1'b1;
        end
    endtask

    task automatic load_image();
        int gap;
        for (int i = 0; i < int'(LOAD_END); i++) begin
            gap        = 8 + int'(next_rand() % 32'd8);
            ioctl_wr   = 1'b1;
            ioctl_addr = loader_addr_t'(i);
            ioctl_dout = image[i];
            @(negedge clk);
            ioctl_wr = 1'b0;
            repeat (gap - 1) @(negedge clk);
        end
    endtask

    task automatic read_main(logic [MAIN_AW-1:0] a);
        main_cs   = 1'b1;
        main_addr = a;
        do @(negedge clk); while (!main_ok);
        expect_equal("main read", 32'(image[int'(a)]), 32'(main_data));
        main_cs = 1'b0;
        @(negedge clk);
    endtask

    task automatic read_snd(logic [SND_AW-1:0] a);
        snd_cs   = 1'b1;
        snd_addr = a;
        do @(negedge clk); while (!snd_ok);
        expect_equal("sound read", 32'(image[int'(BA1_START) + int'(a)]), 32'(snd_data));
        snd_cs = 1'b0;
        @(negedge clk);
    endtask

    // Watchdog sized from the load and the read count
    initial begin
        longint limit;
        limit = (longint'(LOAD_END) * 16 + longint'(64 * N_READS) + 1000) * 4;
        #(limit);
        $display("ERRORS FOUND");
        $fatal(1, "simulation timed out waiting for the DUT");
    end

    initial begin
        reset = 1'b1;
        lvbl = 1'b0;
        {main_cs, snd_cs, obj_cs} = '0;
        {main_addr, snd_addr, char_addr, scr_addr, obj_addr} = '0;
        {ioctl_rom, ioctl_wr, ioctl_addr, ioctl_dout} = '0;
        for (int i = 0; i < int'(LOAD_END); i++) begin
            image[i] = 8'(next_rand() >> 16);
        end
        build_reference();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // Quiet after reset
        expect_true("ok outputs low after reset",
                    !(main_ok || snd_ok || char_ok || scr_ok || obj_ok));
        for (int b = 0; b < 4; b++) begin
            expect_true("read flag low after reset", !bank_req[b].rd);
        end
        expect_true("write flag low after reset", !prog.we);
        expect_equal("busy after reset", 32'd0, 32'(dwnld_busy));

        // Download
        ioctl_rom = 1'b1;
        @(negedge clk);
        expect_equal("busy rise", 32'd1, 32'(dwnld_busy));
        load_image();
        ioctl_rom = 1'b0;
        @(negedge clk);
        expect_equal("busy hold", 32'd1, 32'(dwnld_busy));
        @(negedge clk);
        expect_equal("busy fall", 32'd0, 32'(dwnld_busy));
        expect_true("no write pending after load", !prog.we);
        for (int i = 0; i < 131072; i++) begin
            if (ref_written[i]) begin
                expect_equal("bank image", 32'(ref_mem[i]), 32'(model0.mem[i]));
            end
        end

        // CPU reads run side by side
        for (int i = 0; i < N_CPU; i++) begin
            main_list[i] = MAIN_AW'(next_rand() >> 8);
            snd_list[i]  = SND_AW'(next_rand() >> 8);
        end
        fork
            for (int i = 0; i < N_CPU; i++) read_main(main_list[i]);
            for (int i = 0; i < N_CPU; i++) read_snd(snd_list[i]);
        join

        // Characters and scroll share bank 2
        lvbl = 1'b1;
        for (int i = 0; i < N_GFX; i++) begin
            char_addr = CHAR_AW'(next_rand() >> 8);
            scr_addr  = SCR_AW'(next_rand() >> 8);
            do @(negedge clk); while (!(char_ok && scr_ok));
            expect_equal("char read", 32'(ref_mem[{2'd2, 15'(char_addr)}]), 32'(char_data));
            expect_equal("scroll read",
                         32'(ref_mem[{2'd2, 15'(scr_addr) + 15'(SCR_OFFSET)}]),
                         32'(scr_data));
        end
        lvbl = 1'b0;

        for (int i = 0; i < N_OBJ; i++) begin
            obj_cs   = 1'b1;
            obj_addr = OBJ_AW'(next_rand() >> 8);
            do @(negedge clk); while (!obj_ok);
            expect_equal("object read", 32'(ref_mem[{2'd3, 15'(obj_addr)}]), 32'(obj_data));
        end
        obj_cs = 1'b0;

        // Same address again is a cache hit
        read_main(16'h1234);
        main_cs = 1'b1;
        @(negedge clk);
        expect_true("hit ok on the next cycle", main_ok);
        expect_true("no read flag on a hit", !bank_req[0].rd);
        expect_equal("hit read", 32'(image[16'h1234]), 32'(main_data));
        main_cs = 1'b0;
        @(negedge clk);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/romsys_pkg.sv
hdl/rom_download.sv
hdl/rom_slot.sv
hdl/rom_slot_pair.sv
hdl/game_sdram.sv
dv/sdram_model.sv
dv/tb_game_sdram.sv

/* Makefile */
# Verilator build for the game SDRAM client side

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_game_sdram
RTL_TOP   ?= game_sdram
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: $(BUILD_DIR)/$(TB_TOP)
	-./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
